// File: hw/rv_core_config.svh
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// data path and address width
`define RV_XLEN 32

// architectural integer registers
`define RV_NUM_REGS 32

// index width for the register file
`define RV_REG_AW 5

// first fetch address after reset
`define RV_RESET_PC 32'h8000_0000

`endif

// File: hw/rv_pkg.sv
`include "rv_core_config.svh"

package rv_pkg;

  // one machine word
  typedef logic [`RV_XLEN-1:0] word_t;

  // register file index
  typedef logic [`RV_REG_AW-1:0] reg_addr_t;

  // major opcodes the core executes
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b001_0011,
    OPC_LUI    = 7'b011_0111,
    OPC_AUIPC  = 7'b001_0111,
    OPC_JAL    = 7'b110_1111,
    OPC_JALR   = 7'b110_0111,
    OPC_SYSTEM = 7'b111_0011
  } opcode_e;

  // funct3 of the register-immediate group
  // 001 and 101 are the shifts, left out
  typedef enum logic [2:0] {
    FN_ADDI  = 3'b000,
    FN_SLTI  = 3'b010,
    FN_SLTIU = 3'b011,
    FN_XORI  = 3'b100,
    FN_ORI   = 3'b110,
    FN_ANDI  = 3'b111
  } imm_fn_e;

  // four-phase fetch sequencer
  typedef enum logic [1:0] {
    FS_IDLE    = 2'd0,
    FS_REQ     = 2'd1,
    FS_RELEASE = 2'd2,
    FS_ISSUE   = 2'd3
  } fetch_state_e;

  // why the core stopped
  typedef enum logic [1:0] {
    HALT_NONE    = 2'd0,
    HALT_EBREAK  = 2'd1,
    HALT_ILLEGAL = 2'd2
  } halt_cause_e;

endpackage

// File: hw/rv_fetch.sv
module rv_fetch (
  input  logic          clk,
  input  logic          reset,
  input  logic          halted,
  input  rv_pkg::word_t pc,
  output logic          fetch_req,
  output rv_pkg::word_t fetch_addr,
  input  logic          fetch_ack,
  input  rv_pkg::word_t fetch_data,
  output rv_pkg::word_t inst,
  output logic          inst_valid
);
  import rv_pkg::*;

  fetch_state_e state;
  word_t        addr_q;
  word_t        inst_q;

  // sequencer
  // idle -> req until ack -> release until ack low -> issue one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= FS_IDLE;
    end else begin
      case (state)
        FS_IDLE: begin
          // no new request once the core stopped
          if (!halted) begin
            state <= FS_REQ;
          end
        end
        FS_REQ: begin
          if (fetch_ack) begin
            state <= FS_RELEASE;
          end
        end
        FS_RELEASE: begin
          // wait for the responder to drop ack
          if (!fetch_ack) begin
            state <= FS_ISSUE;
          end
        end
        default: begin
          state <= FS_IDLE;
        end
      endcase
    end
  end

  // address captured from pc as the request opens
  // data captured while ack is high
  always_ff @(posedge clk) begin
    if (state == FS_IDLE && !halted) begin
      addr_q <= pc;
    end
    if (state == FS_REQ && fetch_ack) begin
      inst_q <= fetch_data;
    end
  end

  assign fetch_req  = (state == FS_REQ);
  assign fetch_addr = addr_q;
  assign inst       = inst_q;
  assign inst_valid = (state == FS_ISSUE);

  // request is held until the responder answers
  a_req_held: assert property (@(posedge clk) disable iff (reset)
    (fetch_req && !fetch_ack) |=> fetch_req)
    else $error("fetch_req dropped before fetch_ack");

  // one issue per handshake
  a_issue_single: assert property (@(posedge clk) disable iff (reset)
    inst_valid |=> !inst_valid)
    else $error("inst_valid high on consecutive cycles");

endmodule

// File: hw/rv_decode.sv
`include "rv_core_config.svh"

module rv_decode (
  input  rv_pkg::word_t     inst,
  output rv_pkg::opcode_e   opcode,
  output rv_pkg::imm_fn_e   funct3,
  output rv_pkg::reg_addr_t rd,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::word_t     imm,
  output logic              illegal
);
  import rv_pkg::*;

  localparam word_t EBREAK_INST = 32'h0010_0073;

  word_t imm_i;
  word_t imm_u;
  word_t imm_j;

  // field slices
  // enum casts keep unknown codes visible to the legality check
  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = imm_fn_e'(inst[14:12]);
  assign rd     = inst[11:7];
  assign rs1    = inst[19:15];

  // I type, sign extended
  assign imm_i = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};

  // U type, already in the upper 20 bits
  assign imm_u = {inst[31:12], 12'h000};

  // J type, scrambled offset with implied bit 0
  assign imm_j = {{(`RV_XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // immediate per format
  always_comb begin
    case (opcode)
      OPC_OP_IMM, OPC_JALR: imm = imm_i;
      OPC_LUI, OPC_AUIPC:   imm = imm_u;
      OPC_JAL:              imm = imm_j;
      default:              imm = '0;
    endcase
  end

  // legality
  always_comb begin
    case (opcode)
      OPC_OP_IMM: begin
        // shifts count as unknown
        case (funct3)
          FN_ADDI, FN_SLTI, FN_SLTIU, FN_XORI, FN_ORI, FN_ANDI: illegal = 1'b0;
          default: illegal = 1'b1;
        endcase
      end
      OPC_LUI, OPC_AUIPC, OPC_JAL: begin
        illegal = 1'b0;
      end
      OPC_JALR: begin
        // jalr only defines funct3 000
        illegal = (inst[14:12] != 3'b000);
      end
      OPC_SYSTEM: begin
        // ebreak only, exact encoding
        illegal = (inst != EBREAK_INST);
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

endmodule

// File: hw/rv_execute.sv
module rv_execute (
  input  rv_pkg::opcode_e opcode,
  input  rv_pkg::imm_fn_e funct3,
  input  rv_pkg::word_t   pc,
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   imm,
  output rv_pkg::word_t   result,
  output rv_pkg::word_t   next_pc,
  output logic            reg_wen
);
  import rv_pkg::*;

  word_t seq_pc;
  word_t rs1_sum;
  word_t alu_out;
  logic  lt_signed;
  logic  lt_unsigned;

  // fall-through address, also the link value
  assign seq_pc = pc + word_t'(4);

  // shared by addi and jalr
  assign rs1_sum = rs1_data + imm;

  // compares produce 0 or 1
  assign lt_signed   = ($signed(rs1_data) < $signed(imm));
  assign lt_unsigned = (rs1_data < imm);

  // immediate group ALU
  always_comb begin
    case (funct3)
      FN_ADDI:  alu_out = rs1_sum;
      FN_SLTI:  alu_out = word_t'(lt_signed);
      FN_SLTIU: alu_out = word_t'(lt_unsigned);
      FN_XORI:  alu_out = rs1_data ^ imm;
      FN_ORI:   alu_out = rs1_data | imm;
      FN_ANDI:  alu_out = rs1_data & imm;
      default:  alu_out = '0;
    endcase
  end

  // value written to rd
  always_comb begin
    case (opcode)
      OPC_OP_IMM:        result = alu_out;
      OPC_LUI:           result = imm;
      OPC_AUIPC:         result = pc + imm;
      OPC_JAL, OPC_JALR: result = seq_pc;
      default:           result = '0;
    endcase
  end

  // next pc
  // jalr target has bit 0 forced low
  always_comb begin
    case (opcode)
      OPC_JAL:  next_pc = pc + imm;
      OPC_JALR: next_pc = {rs1_sum[$bits(word_t)-1:1], 1'b0};
      default:  next_pc = seq_pc;
    endcase
  end

  // system writes nothing, neither do unknown opcodes
  always_comb begin
    case (opcode)
      OPC_OP_IMM, OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR: reg_wen = 1'b1;
      default: reg_wen = 1'b0;
    endcase
  end

endmodule

// File: hw/rv_writeback.sv
`include "rv_core_config.svh"

module rv_writeback (
  input  logic                clk,
  input  logic                reset,
  input  logic                inst_valid,
  input  logic                illegal,
  input  rv_pkg::opcode_e     opcode,
  input  rv_pkg::reg_addr_t   rd,
  input  rv_pkg::reg_addr_t   rs1,
  input  rv_pkg::word_t       result,
  input  rv_pkg::word_t       next_pc,
  input  logic                reg_wen,
  output rv_pkg::word_t       pc,
  output rv_pkg::word_t       rs1_data,
  output logic                retire_valid,
  output logic                retire_wen,
  output rv_pkg::word_t       retire_pc,
  output rv_pkg::word_t       retire_data,
  output rv_pkg::reg_addr_t   retire_rd,
  output logic                halted,
  output rv_pkg::halt_cause_e halt_cause
);
  import rv_pkg::*;

  word_t regs [`RV_NUM_REGS];
  logic  stop;
  logic  do_write;

  // halting instruction, illegal or ebreak
  assign stop = illegal || (opcode == OPC_SYSTEM);

  // no write on halt or to x0
  assign do_write = reg_wen && !stop && (rd != '0);

  // x0 always reads zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];

  // register file
  always_ff @(posedge clk) begin
    if (inst_valid && do_write) begin
      regs[rd] <= result;
    end
  end

  // pc, halt and retire control
  always_ff @(posedge clk) begin
    if (reset) begin
      pc           <= `RV_RESET_PC;
      retire_valid <= 1'b0;
      retire_wen   <= 1'b0;
      halted       <= 1'b0;
      halt_cause   <= HALT_NONE;
    end else begin
      // one-cycle trace pulse per commit
      retire_valid <= inst_valid;
      if (inst_valid) begin
        retire_wen <= do_write;
        // a halting instruction leaves pc in place
        if (!stop) begin
          pc <= next_pc;
        end
        if (illegal) begin
          halted     <= 1'b1;
          halt_cause <= HALT_ILLEGAL;
        end else if (opcode == OPC_SYSTEM) begin
          halted     <= 1'b1;
          halt_cause <= HALT_EBREAK;
        end
      end
    end
  end

  // trace payload
  always_ff @(posedge clk) begin
    if (inst_valid) begin
      retire_pc   <= pc;
      retire_rd   <= rd;
      retire_data <= result;
    end
  end

  // fetch must stay quiet after a halt
  a_no_issue_halted: assert property (@(posedge clk) disable iff (reset)
    halted |-> !inst_valid)
    else $error("instruction issued while halted");

endmodule

// File: hw/rv_core_top.sv
module rv_core_top (
  input  logic                clk,
  input  logic                reset,
  output logic                fetch_req,
  output rv_pkg::word_t       fetch_addr,
  input  logic                fetch_ack,
  input  rv_pkg::word_t       fetch_data,
  output logic                retire_valid,
  output logic                retire_wen,
  output rv_pkg::word_t       retire_pc,
  output rv_pkg::word_t       retire_data,
  output rv_pkg::reg_addr_t   retire_rd,
  output logic                halted,
  output rv_pkg::halt_cause_e halt_cause
);
  import rv_pkg::*;

  // fetch to decode
  word_t     inst;
  logic      inst_valid;

  // decoded fields
  opcode_e   opcode;
  imm_fn_e   funct3;
  reg_addr_t rd;
  reg_addr_t rs1;
  word_t     imm;
  logic      illegal;

  // execute results
  word_t     result;
  word_t     next_pc;
  logic      reg_wen;

  // architectural state
  word_t     pc;
  word_t     rs1_data;

  rv_fetch u_fetch (
    .clk        (clk),
    .reset      (reset),
    .halted     (halted),
    .pc         (pc),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .fetch_ack  (fetch_ack),
    .fetch_data (fetch_data),
    .inst       (inst),
    .inst_valid (inst_valid)
  );

  rv_decode u_decode (
    .inst    (inst),
    .opcode  (opcode),
    .funct3  (funct3),
    .rd      (rd),
    .rs1     (rs1),
    .imm     (imm),
    .illegal (illegal)
  );

  rv_execute u_execute (
    .opcode   (opcode),
    .funct3   (funct3),
    .pc       (pc),
    .rs1_data (rs1_data),
    .imm      (imm),
    .result   (result),
    .next_pc  (next_pc),
    .reg_wen  (reg_wen)
  );

  rv_writeback u_writeback (
    .clk          (clk),
    .reset        (reset),
    .inst_valid   (inst_valid),
    .illegal      (illegal),
    .opcode       (opcode),
    .rd           (rd),
    .rs1          (rs1),
    .result       (result),
    .next_pc      (next_pc),
    .reg_wen      (reg_wen),
    .pc           (pc),
    .rs1_data     (rs1_data),
    .retire_valid (retire_valid),
    .retire_wen   (retire_wen),
    .retire_pc    (retire_pc),
    .retire_data  (retire_data),
    .retire_rd    (retire_rd),
    .halted       (halted),
    .halt_cause   (halt_cause)
  );

endmodule

// File: tests/tb_rv_model.svh
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// shadow architectural state
word_t shadow_regs [`RV_NUM_REGS];
word_t shadow_pc;
word_t rng_state = 32'd97;

// xorshift32
function automatic word_t next_rand();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

// executes one instruction on the shadow state, per the RV32I encodings
// returns HALT_NONE for an ordinary retire
function automatic halt_cause_e model_step(input word_t inst, output word_t exp_pc,
    output reg_addr_t exp_rd, output word_t exp_data, output logic exp_wen);
  word_t src;
  word_t i_imm;
  word_t j_imm;
  word_t target;
  halt_cause_e cause;
  src = (inst[19:15] == 5'd0) ? 32'd0 : shadow_regs[inst[19:15]];
  i_imm = {{20{inst[31]}}, inst[31:20]};
  j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  target = shadow_pc + 32'd4;
  cause = HALT_NONE;
  exp_data = 32'd0;
  exp_pc = shadow_pc;
  exp_rd = inst[11:7];
  case (inst[6:0])
    7'h13: begin
      case (inst[14:12])
        3'b000: exp_data = src + i_imm;
        3'b010: exp_data = ($signed(src) < $signed(i_imm)) ? 32'd1 : 32'd0;
        3'b011: exp_data = (src < i_imm) ? 32'd1 : 32'd0;
        3'b100: exp_data = src ^ i_imm;
        3'b110: exp_data = src | i_imm;
        3'b111: exp_data = src & i_imm;
        // shift encodings are not supported
        default: cause = HALT_ILLEGAL;
      endcase
    end
    7'h37: exp_data = {inst[31:12], 12'h000};
    7'h17: exp_data = shadow_pc + {inst[31:12], 12'h000};
    7'h6f: begin
      exp_data = shadow_pc + 32'd4;
      target = shadow_pc + j_imm;
    end
    7'h67: begin
      exp_data = shadow_pc + 32'd4;
      target = (src + i_imm) & ~32'd1;
      if (inst[14:12] != 3'b000)
        cause = HALT_ILLEGAL;
    end
    7'h73: cause = (inst == 32'h0010_0073) ? HALT_EBREAK : HALT_ILLEGAL;
    default: cause = HALT_ILLEGAL;
  endcase
  // halting instructions write nothing and keep pc
  exp_wen = (cause == HALT_NONE) && (exp_rd != 5'd0);
  if (exp_wen)
    shadow_regs[exp_rd] = exp_data;
  if (cause == HALT_NONE)
    shadow_pc = target;
  return cause;
endfunction

task automatic check_word(input string name, input word_t exp, input word_t act);
  if (act !== exp) begin
    $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
    abort_run();
  end
endtask

task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
  if (act !== exp) begin
    $display("[ERROR] t=%0t %s expected %0d actual %0d", $time, name, exp, act);
    abort_run();
  end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("[ERROR] t=%0t %s expected %b actual %b", $time, name, exp, act);
    abort_run();
  end
endtask

task automatic check_cause(input string name, input halt_cause_e exp, input halt_cause_e act);
  if (act !== exp) begin
    $display("[ERROR] t=%0t %s expected %s actual %s(%0d)", $time, name,
             exp.name(), act.name(), act);
    abort_run();
  end
endtask

`endif

// File: tests/tb_rv_core.sv
`include "rv_core_config.svh"

module tb_rv_core;
  import rv_pkg::*;

  localparam int WAIT_LIMIT   = 50;
  localparam int QUIET_CYCLES = 20;

  logic        clk;
  logic        reset;
  logic        fetch_req;
  word_t       fetch_addr;
  logic        fetch_ack;
  word_t       fetch_data;
  logic        retire_valid;
  logic        retire_wen;
  word_t       retire_pc;
  word_t       retire_data;
  reg_addr_t   retire_rd;
  logic        halted;
  halt_cause_e halt_cause;

  // sparse instruction memory
  word_t prog [word_t];

  // legal funct3 codes of the immediate group
  logic [2:0] imm_fns [6] = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b110, 3'b111};

  `include "tb_rv_model.svh"

  rv_core_top u_dut (
    .clk          (clk),
    .reset        (reset),
    .fetch_req    (fetch_req),
    .fetch_addr   (fetch_addr),
    .fetch_ack    (fetch_ack),
    .fetch_data   (fetch_data),
    .retire_valid (retire_valid),
    .retire_wen   (retire_wen),
    .retire_pc    (retire_pc),
    .retire_data  (retire_data),
    .retire_rd    (retire_rd),
    .halted       (halted),
    .halt_cause   (halt_cause)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  // drive and sample point, just after the rising edge
  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic wait_req(input logic level);
    int n;
    n = 0;
    while (fetch_req !== level) begin
      if (n == WAIT_LIMIT) begin
        $display("fetch_req did not reach %b within %0d cycles", level, WAIT_LIMIT);
        abort_run();
      end
      n++;
      tick();
    end
  endtask

  task automatic wait_retire();
    int n;
    n = 0;
    while (retire_valid !== 1'b1) begin
      if (n == WAIT_LIMIT) begin
        $display("no instruction retired within %0d cycles", WAIT_LIMIT);
        abort_run();
      end
      n++;
      tick();
    end
  endtask

  function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
      input logic [2:0] fn, input reg_addr_t rd, input logic [6:0] op);
    return {imm, rs1, fn, rd, op};
  endfunction

  // bit 0 of the offset is implied
  function automatic word_t enc_j(input logic [20:0] off, input reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
  endfunction

  // random register-immediate op, x0 included as source and target
  function automatic word_t rand_imm_op();
    word_t r;
    r = next_rand();
    return enc_i(r[31:20], r[19:15], imm_fns[r[2:0] % 6], r[11:7], 7'h13);
  endfunction

  task automatic apply_reset();
    reset = 1'b1;
    fetch_ack = 1'b0;
    repeat (2) tick();
    check_flag("fetch_req", 1'b0, fetch_req);
    check_flag("retire_valid", 1'b0, retire_valid);
    check_flag("halted", 1'b0, halted);
    check_cause("halt_cause", HALT_NONE, halt_cause);
    reset = 1'b0;
    shadow_pc = `RV_RESET_PC;
  endtask

  // place one instruction at the model pc, serve its fetch and check the retire
  task automatic run_step(input word_t word_in);
    word_t       e_pc;
    word_t       e_data;
    reg_addr_t   e_rd;
    logic        e_wen;
    halt_cause_e e_cause;
    prog[shadow_pc] = word_in;
    e_cause = model_step(word_in, e_pc, e_rd, e_data, e_wen);
    wait_req(1'b1);
    check_word("fetch_addr", e_pc, fetch_addr);
    repeat (next_rand() % 4) tick();
    fetch_data = prog[fetch_addr];
    fetch_ack = 1'b1;
    wait_req(1'b0);
    // slow release of ack
    repeat (next_rand() % 4) tick();
    fetch_ack = 1'b0;
    fetch_data = '0;
    wait_retire();
    check_word("retire_pc", e_pc, retire_pc);
    check_reg("retire_rd", e_rd, retire_rd);
    check_flag("retire_wen", e_wen, retire_wen);
    if (e_cause == HALT_NONE)
      check_word("retire_data", e_data, retire_data);
    check_flag("halted", e_cause != HALT_NONE, halted);
    check_cause("halt_cause", e_cause, halt_cause);
    // a halted core stays off the fetch port
    if (e_cause != HALT_NONE) begin
      repeat (QUIET_CYCLES) begin
        tick();
        if (fetch_req !== 1'b0) begin
          $display("fetch_req rose at %0t after the core halted", $time);
          abort_run();
        end
      end
    end
  endtask

  initial begin
    word_t v;
    reset = 1'b1;
    fetch_ack = 1'b0;
    fetch_data = '0;
    shadow_regs[0] = '0;
    apply_reset();
    // give every register a known value through x0
    for (int r = 1; r < `RV_NUM_REGS; r++) begin
      v = next_rand();
      run_step(enc_i(v[11:0], 5'd0, 3'b000, reg_addr_t'(r), 7'h13));
    end
    repeat (60) run_step(rand_imm_op());
    // lui and auipc
    repeat (20) begin
      v = next_rand();
      run_step({v[31:12], v[11:7], v[0] ? 7'h37 : 7'h17});
    end
    // jumps mixed with ALU ops that read the link registers
    repeat (30) begin
      v = next_rand();
      case (v[1:0])
        2'd0: run_step(enc_j(v[31:11], v[10:6]));
        2'd1: run_step(enc_i(v[31:20], v[19:15], 3'b000, v[11:7], 7'h67));
        default: run_step(rand_imm_op());
      endcase
    end
    run_step(32'h0010_0073);
    // store opcode is unsupported
    apply_reset();
    repeat (4) run_step(rand_imm_op());
    v = next_rand();
    run_step({v[31:7], 7'h23});
    $display("Regression passed");
    $finish;
  end

endmodule

// File: sources.f
+incdir+hw
+incdir+tests
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_writeback.sv
hw/rv_core_top.sv
tests/tb_rv_core.sv
